//--- flist.f
+incdir+sim
hdl/rv_core_pkg.sv
hdl/pipe_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/exec_stage.sv
hdl/rv_dx_top.sv
sim/tb_rv_dx.sv

//--- Bender.yml
package:
  name: rv_dx

sources:
  - files:
      - hdl/rv_core_pkg.sv
      - hdl/pipe_stage.sv
      - hdl/reg_file.sv
      - hdl/decode_stage.sv
      - hdl/exec_stage.sv
      - hdl/rv_dx_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rv_dx.sv

//--- sim/tb_vectors.svh
// x1 19, x2 -7, x3 min int, x4 5, x5 pattern, x6 equal to x1, x7 odd for jalr
task load_regs();
    write_reg(5'd1, 32'h00000013);
    write_reg(5'd2, 32'hfffffff9);
    write_reg(5'd3, 32'h80000000);
    write_reg(5'd4, 32'h00000005);
    write_reg(5'd5, 32'h12345678);
    write_reg(5'd6, 32'h00000013);
    write_reg(5'd7, 32'h00001001);
endtask

// each entry is pc, instruction word, then expected rd and value, or taken flag and target
task build_table();
    push_alu(32'h200, r_type(f7_base, 5'd2, 5'd1, f3_add, 5'd8, op_reg), 5'd8, 32'h0000000c);
    push_alu(32'h204, r_type(f7_alt, 5'd2, 5'd1, f3_add, 5'd9, op_reg), 5'd9, 32'h0000001a);
    push_alu(32'h208, r_type(f7_base, 5'd2, 5'd1, f3_and, 5'd10, op_reg), 5'd10, 32'h00000011);
    push_alu(32'h20c, r_type(f7_base, 5'd4, 5'd3, f3_or, 5'd11, op_reg), 5'd11, 32'h80000005);
    push_alu(32'h210, r_type(f7_base, 5'd2, 5'd5, f3_xor, 5'd12, op_reg), 5'd12, 32'hedcba981);
    push_alu(32'h214, r_type(f7_base, 5'd4, 5'd5, f3_sll, 5'd13, op_reg), 5'd13, 32'h468acf00);
    push_alu(32'h218, r_type(f7_base, 5'd4, 5'd2, f3_srl, 5'd14, op_reg), 5'd14, 32'h07ffffff);
    push_alu(32'h21c, r_type(f7_alt, 5'd4, 5'd2, f3_srl, 5'd15, op_reg), 5'd15, 32'hffffffff);
    push_alu(32'h220, r_type(f7_base, 5'd1, 5'd2, f3_slt, 5'd16, op_reg), 5'd16, 32'h00000001);
    push_alu(32'h224, r_type(f7_base, 5'd1, 5'd2, f3_sltu, 5'd17, op_reg), 5'd17, 32'h00000000);
    push_alu(32'h228, r_type(f7_base, 5'd5, 5'd0, f3_add, 5'd18, op_reg), 5'd18, 32'h12345678);
    push_alu(32'h22c, i_type(12'hfec, 5'd1, f3_add, 5'd19, op_imm), 5'd19, 32'hffffffff);
    push_alu(32'h230, i_type(12'h0ff, 5'd5, f3_and, 5'd20, op_imm), 5'd20, 32'h00000078);
    push_alu(32'h234, i_type(12'h800, 5'd4, f3_or, 5'd21, op_imm), 5'd21, 32'hfffff805);
    push_alu(32'h238, i_type(12'hfff, 5'd1, f3_xor, 5'd22, op_imm), 5'd22, 32'hffffffec);
    push_alu(32'h23c, i_type(12'hffa, 5'd2, f3_slt, 5'd23, op_imm), 5'd23, 32'h00000001);
    push_alu(32'h240, i_type(12'hfff, 5'd1, f3_sltu, 5'd24, op_imm), 5'd24, 32'h00000001);
    push_alu(32'h244, i_type(12'h003, 5'd4, f3_sll, 5'd25, op_imm), 5'd25, 32'h00000028);
    push_alu(32'h248, i_type(12'h004, 5'd3, f3_srl, 5'd26, op_imm), 5'd26, 32'h08000000);
    push_alu(32'h24c, i_type(12'h404, 5'd3, f3_srl, 5'd27, op_imm), 5'd27, 32'hf8000000);
    push_alu(32'h250, u_type(20'habcde, 5'd28, op_lui), 5'd28, 32'habcde000);
    push_alu(32'h254, u_type(20'h00001, 5'd29, op_auipc), 5'd29, 32'h00001254);
    push_branch(32'h258, b_type(f3_beq, 5'd1, 5'd6, 13'h0010), 1'b1, 32'h268);
    push_branch(32'h25c, b_type(f3_beq, 5'd1, 5'd2, 13'h0010), 1'b0, 32'h260);
    push_branch(32'h260, b_type(f3_bne, 5'd1, 5'd2, 13'h1ff8), 1'b1, 32'h258); // backward
    push_branch(32'h264, b_type(f3_bne, 5'd1, 5'd6, 13'h1ff8), 1'b0, 32'h268);
    push_branch(32'h268, b_type(f3_blt, 5'd2, 5'd1, 13'h0010), 1'b1, 32'h278);
    push_branch(32'h26c, b_type(f3_blt, 5'd1, 5'd2, 13'h0010), 1'b0, 32'h270);
    push_branch(32'h270, b_type(f3_bge, 5'd1, 5'd2, 13'h0010), 1'b1, 32'h280);
    push_branch(32'h274, b_type(f3_bge, 5'd2, 5'd1, 13'h0010), 1'b0, 32'h278);
    push_branch(32'h278, b_type(f3_bltu, 5'd1, 5'd2, 13'h1ff8), 1'b1, 32'h270);
    push_branch(32'h27c, b_type(f3_bltu, 5'd2, 5'd1, 13'h1ff8), 1'b0, 32'h280);
    push_branch(32'h280, b_type(f3_bgeu, 5'd2, 5'd1, 13'h0010), 1'b1, 32'h290);
    push_branch(32'h284, b_type(f3_bgeu, 5'd1, 5'd2, 13'h0010), 1'b0, 32'h288);
    push_jump(32'h288, j_type(5'd30, 21'h000100), 5'd30, 32'h00000388);
    push_jump(32'h28c, j_type(5'd31, 21'h1fffe0), 5'd31, 32'h0000026c);
    push_jump(32'h290, i_type(12'h004, 5'd7, f3_add, 5'd30, op_jalr), 5'd30, 32'h00001004);
    push_jump(32'h294, i_type(12'h008, 5'd2, f3_add, 5'd31, op_jalr), 5'd31, 32'h00000000);
    push_illegal(32'h298, i_type(12'h004, 5'd1, 3'b010, 5'd8, 7'b0000011)); // lw
    push_illegal(32'h29c, r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8, 7'b0100011)); // sw
    push_illegal(32'h2a0, i_type(12'h300, 5'd1, 3'b001, 5'd8, 7'b1110011)); // csrrw
    push_illegal(32'h2a4, 32'h00000073); // ecall
    push_illegal(32'h2a8, 32'h00000000);
    push_illegal(32'h2ac, i_type(12'h204, 5'd3, f3_srl, 5'd9, op_imm)); // bad srli funct7
endtask

//--- sim/tb_rv_dx.sv
`timescale 1ns/10ps

module tb_rv_dx
    import rv_core_pkg::*;
();

    logic         clk = 1'b0;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    inst_req_t    in_req;
    logic         out_valid;
    logic         out_ready = 1'b1;
    exec_result_t out_res;
    rf_write_t    rf_wr;

    inst_req_t    reqs[$];
    exec_result_t exps[$];
    int           n_out = 0;
    int           n_pass = 0;
    int           n_fail = 0;
    int           cycles = 0;
    logic         random_ready;
    logic [31:0]  rng = 32'hd469_8bb3;

    rv_dx_top i_dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
        input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] value);
        rf_wr.wen  <= 1'b1;
        rf_wr.addr <= idx;
        rf_wr.data <= value;
        @(posedge clk);
        rf_wr <= '0;
    endtask

    task automatic push_alu(input logic [31:0] pc, input logic [31:0] inst,
        input logic [4:0] rd, input logic [31:0] wb);
        reqs.push_back({pc, inst});
        exps.push_back({pc, wb, rd, 1'b1, 1'b0, pc + 32'd4, 1'b0});
    endtask

    task automatic push_branch(input logic [31:0] pc, input logic [31:0] inst,
        input logic taken, input logic [31:0] npc);
        reqs.push_back({pc, inst});
        exps.push_back({pc, 32'h0, 5'd0, 1'b0, taken, npc, 1'b0});
    endtask

    task automatic push_jump(input logic [31:0] pc, input logic [31:0] inst,
        input logic [4:0] rd, input logic [31:0] npc);
        reqs.push_back({pc, inst});
        exps.push_back({pc, pc + 32'd4, rd, 1'b1, 1'b0, npc, 1'b0}); // link is pc+4
    endtask

    task automatic push_illegal(input logic [31:0] pc, input logic [31:0] inst);
        reqs.push_back({pc, inst});
        exps.push_back({pc, 32'h0, 5'd0, 1'b0, 1'b0, pc + 32'd4, 1'b1});
    endtask

    `include "tb_vectors.svh"

    function automatic bit match_field(input int idx, input string name,
        input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] test %0d %s: got %h expected %h", idx, name, got, exp);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_result(input int idx, input exec_result_t got, input exec_result_t exp);
        bit ok;
        ok = match_field(idx, "pc", got.pc, exp.pc);
        ok &= match_field(idx, "rf_wen", 32'(got.rf_wen), 32'(exp.rf_wen));
        ok &= match_field(idx, "br_taken", 32'(got.br_taken), 32'(exp.br_taken));
        ok &= match_field(idx, "next_pc", got.next_pc, exp.next_pc);
        ok &= match_field(idx, "illegal", 32'(got.illegal), 32'(exp.illegal));
        if (exp.rf_wen) begin // value and rd only mean something when written back
            ok &= match_field(idx, "wb_value", got.wb_value, exp.wb_value);
            ok &= match_field(idx, "rd", 32'(got.rd), 32'(exp.rd));
        end
        if (ok) begin
            n_pass++;
            $display("[PASS] test %0d pc %h", idx, got.pc);
        end else begin
            n_fail++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            n_fail++;
        end else begin
            $display("[PASS] %s", name);
            n_pass++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s result count: got %h expected %h", name, got, exp);
            n_fail++;
        end else begin
            $display("[PASS] %s result count %0d", name, got);
            n_pass++;
        end
    endtask

    task automatic send_table();
        for (int i = 0; i < reqs.size(); i++) begin
            in_valid <= 1'b1;
            in_req   <= reqs[i];
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_results(input int target);
        while (n_out < target) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk); // late duplicates would show up here
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (random_ready) begin
            rng       <= xorshift32(rng);
            out_ready <= rng[3];
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (n_out >= 2 * exps.size()) begin
                $display("unexpected extra result at pc %h beyond the table", out_res.pc);
                n_fail++;
            end else begin
                check_result(n_out, out_res, exps[n_out % exps.size()]);
            end
            n_out <= n_out + 1;
        end
    end

    initial begin
        while (cycles < 2 * exps.size() * 8 + 200) begin
            @(posedge clk);
        end
        $display("timeout: results still missing after %0d cycles", cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_req       = '0;
        rf_wr        = '0;
        random_ready = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("out_valid after reset", out_valid, 1'b0);
        check_flag("in_ready after reset", in_ready, 1'b1);
        load_regs();
        send_table();
        wait_results(exps.size());
        check_count("first pass", n_out, exps.size());
        random_ready <= 1'b1; // second pass under back-pressure
        send_table();
        wait_results(2 * exps.size());
        random_ready <= 1'b0;
        check_count("second pass", n_out - exps.size(), exps.size());
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- hdl/rv_dx_top.sv
`timescale 1ns/10ps

module rv_dx_top
    import rv_core_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  inst_req_t    in_req,
    output logic         out_valid,
    input  logic         out_ready,
    output exec_result_t out_res,
    input  rf_write_t    rf_wr
);

    logic                  req_valid;
    logic                  req_ready;
    inst_req_t             req;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic                  dec_valid;
    logic                  dec_ready;
    decoded_t              dec;
    logic                  res_valid;
    logic                  res_ready;
    exec_result_t          res;

    pipe_stage #(.payload_t(inst_req_t)) u_in_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_req),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_req    (req),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_dec   (dec)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wr       (rf_wr)
    );

    exec_stage u_exec (
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_dec    (dec),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_res   (res)
    );

    pipe_stage #(.payload_t(exec_result_t)) u_out_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (res_valid),
        .in_ready  (res_ready),
        .in_data   (res),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_res)
    );

endmodule

//--- hdl/exec_stage.sv
`timescale 1ns/10ps

module exec_stage
    import rv_core_pkg::*;
(
    input  logic         in_valid,
    output logic         in_ready,
    input  decoded_t     in_dec,
    output logic         out_valid,
    input  logic         out_ready,
    output exec_result_t out_res
);

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] pc4;
    logic            taken;

    assign op1   = in_dec.op1;
    assign op2   = in_dec.op2;
    assign shamt = op2[4:0];
    assign pc4   = in_dec.pc + xlen'(4);

    always_comb begin
        case (in_dec.alu_op)
            alu_add:   alu_res = op1 + op2;
            alu_sub:   alu_res = op1 - op2;
            alu_and:   alu_res = op1 & op2;
            alu_or:    alu_res = op1 | op2;
            alu_xor:   alu_res = op1 ^ op2;
            alu_sll:   alu_res = op1 << shamt;
            alu_srl:   alu_res = op1 >> shamt;
            alu_sra:   alu_res = $signed(op1) >>> shamt;
            alu_slt:   alu_res = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
            alu_sltu:  alu_res = {{(xlen-1){1'b0}}, op1 < op2};
            alu_copy2: alu_res = op2;
            alu_jalr:  alu_res = (op1 + op2) & ~xlen'(1); // target is halfword aligned
            default:   alu_res = op1 + op2;
        endcase
    end

    always_comb begin
        case (in_dec.br_op)
            br_beq:  taken = op1 == in_dec.rs2_val;
            br_bne:  taken = op1 != in_dec.rs2_val;
            br_blt:  taken = $signed(op1) < $signed(in_dec.rs2_val);
            br_bge:  taken = $signed(op1) >= $signed(in_dec.rs2_val);
            br_bltu: taken = op1 < in_dec.rs2_val;
            br_bgeu: taken = op1 >= in_dec.rs2_val;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        out_res.pc       = in_dec.pc;
        out_res.wb_value = (in_dec.wb_sel == wb_pc4) ? pc4 : alu_res;
        out_res.rd       = in_dec.rd;
        out_res.rf_wen   = in_dec.rf_wen && !in_dec.illegal;
        out_res.br_taken = taken;
        out_res.illegal  = in_dec.illegal;
        if (taken) begin
            out_res.next_pc = in_dec.pc + in_dec.imm_b;
        end else if (in_dec.is_jal) begin
            out_res.next_pc = in_dec.pc + in_dec.imm_j;
        end else if (in_dec.alu_op == alu_jalr) begin
            out_res.next_pc = alu_res;
        end else begin
            out_res.next_pc = pc4;
        end
    end

    // no storage here, handshake passes straight through
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
    import rv_core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  inst_req_t             in_req,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    input  logic [xlen-1:0]       rs1_val,
    input  logic [xlen-1:0]       rs2_val,
    output logic                  out_valid,
    input  logic                  out_ready,
    output decoded_t              out_dec
);

    typedef enum logic [1:0] {op1_rs1, op1_pc, op1_zero} op1_sel_e;
    typedef enum logic [1:0] {op2_rs2, op2_imi, op2_imu} op2_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        br_op_e   br_op;
        wb_sel_e  wb_sel;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        logic     rf_wen;
        logic     is_jal;
        logic     illegal;
    } ctrl_t;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_u;
    ctrl_t           ctrl;
    decoded_t        dec_d;
    decoded_t        dec_q;
    logic            valid_q;

    assign inst   = in_req.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    // control table, anything not matched stays illegal
    always_comb begin
        ctrl = '{alu_add, br_none, wb_alu, op1_zero, op2_imi, 1'b0, 1'b0, 1'b1};
        case (opcode)
            op_lui:   ctrl = '{alu_copy2, br_none, wb_alu, op1_zero, op2_imu, 1'b1, 1'b0, 1'b0};
            op_auipc: ctrl = '{alu_add,   br_none, wb_alu, op1_pc,   op2_imu, 1'b1, 1'b0, 1'b0};
            op_jal:   ctrl = '{alu_add,   br_none, wb_pc4, op1_pc,   op2_imi, 1'b1, 1'b1, 1'b0};
            op_jalr: begin
                if (funct3 == f3_add) begin
                    ctrl = '{alu_jalr, br_none, wb_pc4, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                end
            end
            op_branch: begin
                case (funct3)
                    f3_beq:  ctrl = '{alu_sub, br_beq,  wb_alu, op1_rs1, op2_rs2, 1'b0, 1'b0, 1'b0};
                    f3_bne:  ctrl = '{alu_sub, br_bne,  wb_alu, op1_rs1, op2_rs2, 1'b0, 1'b0, 1'b0};
                    f3_blt:  ctrl = '{alu_sub, br_blt,  wb_alu, op1_rs1, op2_rs2, 1'b0, 1'b0, 1'b0};
                    f3_bge:  ctrl = '{alu_sub, br_bge,  wb_alu, op1_rs1, op2_rs2, 1'b0, 1'b0, 1'b0};
                    f3_bltu: ctrl = '{alu_sub, br_bltu, wb_alu, op1_rs1, op2_rs2, 1'b0, 1'b0, 1'b0};
                    f3_bgeu: ctrl = '{alu_sub, br_bgeu, wb_alu, op1_rs1, op2_rs2, 1'b0, 1'b0, 1'b0};
                    default: ;
                endcase
            end
            op_imm: begin
                case (funct3)
                    f3_add:  ctrl = '{alu_add,  br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                    f3_slt:  ctrl = '{alu_slt,  br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                    f3_sltu: ctrl = '{alu_sltu, br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                    f3_xor:  ctrl = '{alu_xor,  br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                    f3_or:   ctrl = '{alu_or,   br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                    f3_and:  ctrl = '{alu_and,  br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                    f3_sll: begin
                        if (funct7 == f7_base) begin
                            ctrl = '{alu_sll, br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                        end
                    end
                    f3_srl: begin
                        if (funct7 == f7_base) begin
                            ctrl = '{alu_srl, br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                        end else if (funct7 == f7_alt) begin
                            ctrl = '{alu_sra, br_none, wb_alu, op1_rs1, op2_imi, 1'b1, 1'b0, 1'b0};
                        end
                    end
                    default: ;
                endcase
            end
            op_reg: begin
                case ({funct7, funct3})
                    {f7_base, f3_add}:  ctrl = '{alu_add,  br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_alt,  f3_add}:  ctrl = '{alu_sub,  br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_base, f3_sll}:  ctrl = '{alu_sll,  br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_base, f3_slt}:  ctrl = '{alu_slt,  br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_base, f3_sltu}: ctrl = '{alu_sltu, br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_base, f3_xor}:  ctrl = '{alu_xor,  br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_base, f3_srl}:  ctrl = '{alu_srl,  br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_alt,  f3_srl}:  ctrl = '{alu_sra,  br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_base, f3_or}:   ctrl = '{alu_or,   br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    {f7_base, f3_and}:  ctrl = '{alu_and,  br_none, wb_alu, op1_rs1, op2_rs2, 1'b1, 1'b0, 1'b0};
                    default: ;
                endcase
            end
            default: ; // loads, stores, system
        endcase
    end

    always_comb begin
        dec_d.pc      = in_req.pc;
        dec_d.op1     = (ctrl.op1_sel == op1_rs1) ? rs1_val :
                        (ctrl.op1_sel == op1_pc)  ? in_req.pc : '0;
        dec_d.op2     = (ctrl.op2_sel == op2_rs2) ? rs2_val :
                        (ctrl.op2_sel == op2_imu) ? imm_u : imm_i;
        dec_d.rs2_val = rs2_val;
        dec_d.imm_b   = imm_b;
        dec_d.imm_j   = imm_j;
        dec_d.alu_op  = ctrl.alu_op;
        dec_d.br_op   = ctrl.br_op;
        dec_d.wb_sel  = ctrl.wb_sel;
        dec_d.rd      = inst[11:7];
        dec_d.rf_wen  = ctrl.rf_wen;
        dec_d.is_jal  = ctrl.is_jal;
        dec_d.illegal = ctrl.illegal;
    end

    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_dec   = dec_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_q <= dec_d; // operands sampled with the instruction
        end
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import rv_core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    output logic [xlen-1:0]       rs1_val,
    output logic [xlen-1:0]       rs2_val,
    input  rf_write_t             wr
);

    logic [xlen-1:0] regs [1:31]; // no storage behind x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wen && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hdl/pipe_stage.sv
`timescale 1ns/10ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // refill in the same cycle the held item leaves
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // alu funct3
    localparam logic [2:0] f3_add  = 3'b000; // add, sub, addi, jalr
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101; // srl and sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra, srai

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra,
        alu_slt, alu_sltu, alu_copy2, alu_jalr
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } br_op_e;

    typedef enum logic {wb_alu, wb_pc4} wb_sel_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } inst_req_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       op1;
        logic [xlen-1:0]       op2;
        logic [xlen-1:0]       rs2_val; // branch compare
        logic [xlen-1:0]       imm_b;
        logic [xlen-1:0]       imm_j;
        alu_op_e               alu_op;
        br_op_e                br_op;
        wb_sel_e               wb_sel;
        logic [reg_addr_w-1:0] rd;
        logic                  rf_wen;
        logic                  is_jal;
        logic                  illegal;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       wb_value;
        logic [reg_addr_w-1:0] rd;
        logic                  rf_wen;
        logic                  br_taken;
        logic [xlen-1:0]       next_pc;
        logic                  illegal;
    } exec_result_t;

    typedef struct packed {
        logic                  wen;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } rf_write_t;

endpackage
